// ==== common/riscv_defs.svh ====
// Core-wide constants
// Data width, reset PC, debug address map
// Major opcodes of the supported instruction set

`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

////////////////////////////////////////////////////////////
// Widths and reset vector
////////////////////////////////////////////////////////////
`define XLEN           32
`define PC_INIT        32'h0000_0200   // First fetch address

////////////////////////////////////////////////////////////
// Debug address map
////////////////////////////////////////////////////////////
`define DBG_ADDR_SIZE  16
`define DBG_GPR_BASE   16'h1000        // x0, then x1..x31 upwards

////////////////////////////////////////////////////////////
// Major opcodes
////////////////////////////////////////////////////////////
`define OPC_OP         7'b0110011      // Register-register ALU
`define OPC_OP_IMM     7'b0010011      // Register-immediate ALU
`define OPC_LUI        7'b0110111

`endif

// ==== common/riscv_pkg.sv ====
// Shared types of the integer pipeline
// Instruction word, register index, ALU function
// Field extraction helpers for the decoder

package riscv_pkg;

  `include "riscv_defs.svh"

  typedef logic [31:0] instruction_t;  // Raw instruction word
  typedef logic [ 4:0] rsd_t;          // Register index

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASSB                          // LUI passes operand B
  } alu_op_t;

  // I-type immediate, sign extended
  function automatic logic [`XLEN-1:0] imm_i(input instruction_t insn);
    return {{(`XLEN-12){insn[31]}}, insn[31:20]};
  endfunction

  // U-type immediate, low 12 bits zero
  function automatic logic [`XLEN-1:0] imm_u(input instruction_t insn);
    return {insn[31:12], 12'h000};
  endfunction

endpackage

// ==== common/riscv_id_ex_if.sv ====
// Decode to execute link
// One decoded ALU operation with its operands

`timescale 1ns/100ps

`include "riscv_defs.svh"

interface riscv_id_ex_if;

  logic                valid;  // Stage holds an instruction
  riscv_pkg::alu_op_t  alu_op;
  logic [`XLEN-1:0]    opa;
  logic [`XLEN-1:0]    opb;
  riscv_pkg::rsd_t     dst;
  logic                we;     // Low for no-ops and x0

  modport id (output valid, alu_op, opa, opb, dst, we);
  modport ex (input  valid, alu_op, opa, opb, dst, we);

endinterface

// ==== core/riscv_if.sv ====
// Instruction fetch stage
// Program counter, fetch request handshake, fetch register

`timescale 1ns/100ps

`include "riscv_defs.svh"

module riscv_if (
  input  logic                    clk_i,
  input  logic                    arst_n_i,

  output logic [`XLEN-1:0]        imem_adr_o,
  output logic                    imem_req_o,
  input  logic                    imem_ack_i,
  input  logic [`XLEN-1:0]        imem_parcel_i,

  input  logic                    du_stall_i,

  output logic                    if_valid_o,
  output riscv_pkg::instruction_t if_insn_o
);

  logic fetch_done;  // Open request completes this cycle

  assign fetch_done = imem_req_o & imem_ack_i;

  // PC and request control
  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
    begin
      imem_adr_o <= `PC_INIT;
      imem_req_o <= 1'b0;
      if_valid_o <= 1'b0;
    end
    else
    begin
      if_valid_o <= fetch_done;
      if (fetch_done) imem_adr_o <= imem_adr_o + 'd4;

      // Under debug stall the open request still runs to its ack
      if (!imem_req_o || imem_ack_i) imem_req_o <= ~du_stall_i;
    end

  // Fetch register
  always_ff @(posedge clk_i)
    if (fetch_done) if_insn_o <= imem_parcel_i;

  // A waiting request keeps its address
  a_adr_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    imem_req_o && !imem_ack_i |=> imem_req_o && $stable(imem_adr_o));

endmodule

// ==== core/riscv_id.sv ====
// Instruction decode stage
// Opcode decode, immediate generation, operand bypass
// Decode register towards execute

`timescale 1ns/100ps

`include "riscv_defs.svh"

module riscv_id (
  input  logic                    clk_i,
  input  logic                    arst_n_i,

  input  logic                    if_valid_i,
  input  riscv_pkg::instruction_t if_insn_i,

  // Register file read
  output riscv_pkg::rsd_t         rf_src1_o,
  output riscv_pkg::rsd_t         rf_src2_o,
  input  logic [`XLEN-1:0]        rf_srcv1_i,
  input  logic [`XLEN-1:0]        rf_srcv2_i,

  // Bypass sources
  input  logic [`XLEN-1:0]        ex_r_i,
  input  logic                    wb_we_i,
  input  riscv_pkg::rsd_t         wb_dst_i,
  input  logic [`XLEN-1:0]        wb_r_i,

  riscv_id_ex_if.id               id_ex
);

  logic [6:0]         opcode, funct7;
  logic [2:0]         funct3;
  riscv_pkg::rsd_t    rd;
  logic               alt;        // SUB or SRA variant
  logic               f7_ok;
  logic               legal;
  riscv_pkg::alu_op_t alu_op;
  logic [`XLEN-1:0]   opa, opb;

  assign opcode    = if_insn_i[ 6: 0];
  assign rd        = if_insn_i[11: 7];
  assign funct3    = if_insn_i[14:12];
  assign funct7    = if_insn_i[31:25];
  assign rf_src1_o = if_insn_i[19:15];
  assign rf_src2_o = if_insn_i[24:20];

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////
  assign alt   = if_insn_i[30] & (opcode == `OPC_OP || funct3 == 3'b101);
  assign f7_ok = (funct7 == 7'h00) ||
                 (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb
  begin
    case (funct3)
      3'b000 : alu_op = alt ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
      3'b001 : alu_op = riscv_pkg::ALU_SLL;
      3'b010 : alu_op = riscv_pkg::ALU_SLT;
      3'b011 : alu_op = riscv_pkg::ALU_SLTU;
      3'b100 : alu_op = riscv_pkg::ALU_XOR;
      3'b101 : alu_op = alt ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
      3'b110 : alu_op = riscv_pkg::ALU_OR;
      default: alu_op = riscv_pkg::ALU_AND;
    endcase

    case (opcode)
      `OPC_OP    : legal = f7_ok;
      `OPC_OP_IMM: legal = (funct3[1:0] != 2'b01) || f7_ok;  // Shifts check funct7
      `OPC_LUI   : legal = 1'b1;
      default    : legal = 1'b0;                             // Retires as no-op
    endcase

    if (opcode == `OPC_LUI) alu_op = riscv_pkg::ALU_PASSB;
  end

  ////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////
  // Youngest producer wins
  function automatic logic [`XLEN-1:0] bypass(input riscv_pkg::rsd_t  src,
                                              input logic [`XLEN-1:0] rfv);
    if (id_ex.we && id_ex.dst == src) return ex_r_i;
    else if (wb_we_i && wb_dst_i == src) return wb_r_i;
    else return rfv;
  endfunction

  always_comb
  begin
    opa = bypass(rf_src1_o, rf_srcv1_i);
    case (opcode)
      `OPC_OP    : opb = bypass(rf_src2_o, rf_srcv2_i);
      `OPC_OP_IMM: opb = riscv_pkg::imm_i(if_insn_i);
      default    : opb = riscv_pkg::imm_u(if_insn_i);
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Decode register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
    begin
      id_ex.valid <= 1'b0;
      id_ex.we    <= 1'b0;
    end
    else
    begin
      id_ex.valid <= if_valid_i;
      id_ex.we    <= if_valid_i & legal & (rd != '0);
    end

  always_ff @(posedge clk_i)
    if (if_valid_i)
    begin
      id_ex.alu_op <= alu_op;
      id_ex.opa    <= opa;
      id_ex.opb    <= opb;
      id_ex.dst    <= rd;
    end

  // x0 is never a write-back target
  a_no_x0_write : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    id_ex.we |-> id_ex.valid && id_ex.dst != '0);

endmodule

// ==== core/riscv_ex.sv ====
// Execute stage
// ALU and write-back register

`timescale 1ns/100ps

`include "riscv_defs.svh"

module riscv_ex (
  input  logic             clk_i,
  input  logic             arst_n_i,

  riscv_id_ex_if.ex        id_ex,

  output logic [`XLEN-1:0] ex_r_o,   // Also fed back for bypass
  output logic             wb_we_o,
  output riscv_pkg::rsd_t  wb_dst_o,
  output logic [`XLEN-1:0] wb_r_o
);

  logic [4:0] shamt;

  assign shamt = id_ex.opb[4:0];

  // ALU
  always_comb
    case (id_ex.alu_op)
      riscv_pkg::ALU_ADD  : ex_r_o = id_ex.opa + id_ex.opb;
      riscv_pkg::ALU_SUB  : ex_r_o = id_ex.opa - id_ex.opb;
      riscv_pkg::ALU_SLL  : ex_r_o = id_ex.opa << shamt;
      riscv_pkg::ALU_SLT  : ex_r_o = {{(`XLEN-1){1'b0}},
                                      $signed(id_ex.opa) < $signed(id_ex.opb)};
      riscv_pkg::ALU_SLTU : ex_r_o = {{(`XLEN-1){1'b0}}, id_ex.opa < id_ex.opb};
      riscv_pkg::ALU_XOR  : ex_r_o = id_ex.opa ^ id_ex.opb;
      riscv_pkg::ALU_SRL  : ex_r_o = id_ex.opa >> shamt;
      riscv_pkg::ALU_SRA  : ex_r_o = $unsigned($signed(id_ex.opa) >>> shamt);
      riscv_pkg::ALU_OR   : ex_r_o = id_ex.opa | id_ex.opb;
      riscv_pkg::ALU_AND  : ex_r_o = id_ex.opa & id_ex.opb;
      default             : ex_r_o = id_ex.opb;  // PASSB
    endcase

  ////////////////////////////////////////////////////////////
  // Write-back register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i) wb_we_o <= 1'b0;
    else           wb_we_o <= id_ex.valid & id_ex.we;

  always_ff @(posedge clk_i)
    if (id_ex.valid)
    begin
      wb_dst_o <= id_ex.dst;
      wb_r_o   <= ex_r_o;
    end

endmodule

// ==== core/riscv_rf.sv ====
// Integer register file
// 31 writable registers, x0 reads zero
// Two pipeline read ports, one write port shared with debug

`timescale 1ns/100ps

`include "riscv_defs.svh"

module riscv_rf (
  input  logic             clk_i,
  input  logic             arst_n_i,

  input  riscv_pkg::rsd_t  rf_src1_i,
  input  riscv_pkg::rsd_t  rf_src2_i,
  output logic [`XLEN-1:0] rf_srcv1_o,
  output logic [`XLEN-1:0] rf_srcv2_o,

  input  logic             rf_we_i,
  input  riscv_pkg::rsd_t  rf_dst_i,
  input  logic [`XLEN-1:0] rf_d_i,

  input  logic             du_re_rf_i,
  input  logic             du_we_rf_i,
  input  riscv_pkg::rsd_t  du_addr_i,
  input  logic [`XLEN-1:0] du_d_i,
  output logic [`XLEN-1:0] du_rf_q_o
);

  logic [`XLEN-1:0] mem [1:31];

  function automatic logic [`XLEN-1:0] rd_reg(input riscv_pkg::rsd_t idx);
    return (idx == '0) ? '0 : mem[idx];
  endfunction

  assign rf_srcv1_o = rd_reg(rf_src1_i);
  assign rf_srcv2_o = rd_reg(rf_src2_i);

  // Debug owns the write port while the pipeline is drained
  always_ff @(posedge clk_i)
    if (du_we_rf_i)
    begin
      if (du_addr_i != '0) mem[du_addr_i] <= du_d_i;
    end
    else if (rf_we_i && rf_dst_i != '0) mem[rf_dst_i] <= rf_d_i;

  always_ff @(posedge clk_i)
    if (du_re_rf_i) du_rf_q_o <= rd_reg(du_addr_i);

  a_one_writer : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !(rf_we_i && du_we_rf_i));

endmodule

// ==== debug/riscv_du.sv ====
// Debug unit
// Core stall, drain detection, GPR access sequencing

`timescale 1ns/100ps

`include "riscv_defs.svh"

module riscv_du (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  // Debug bus
  input  logic                      dbg_stall_i,
  input  logic                      dbg_strb_i,
  input  logic                      dbg_we_i,
  input  logic [`DBG_ADDR_SIZE-1:0] dbg_addr_i,
  input  logic [`XLEN         -1:0] dbg_dati_i,
  output logic [`XLEN         -1:0] dbg_dato_o,
  output logic                      dbg_ack_o,

  // Pipeline status
  output logic                      du_stall_o,
  input  logic                      if_valid_i,
  input  logic                      id_valid_i,
  input  logic                      wb_we_i,
  input  logic                      imem_req_i,

  // Register file access
  output logic                      du_re_rf_o,
  output logic                      du_we_rf_o,
  output riscv_pkg::rsd_t           du_addr_o,
  output logic [`XLEN         -1:0] du_dato_o,
  input  logic [`XLEN         -1:0] du_rf_q_i
);

  localparam logic [`DBG_ADDR_SIZE-1:0] GPR_BASE = `DBG_GPR_BASE;

  logic drained;
  logic gpr_hit;   // Address falls in x0..x31
  logic start;
  logic acc_q;     // Access cycle
  logic rd_hit_q;  // Ack carries register data

  assign du_stall_o = dbg_stall_i;
  assign drained    = ~(if_valid_i | id_valid_i | wb_we_i | imem_req_i);
  assign gpr_hit    = dbg_addr_i[`DBG_ADDR_SIZE-1:5] == GPR_BASE[`DBG_ADDR_SIZE-1:5];

  // Strobe is held until ack, so no start in access or ack cycle
  assign start      = dbg_stall_i & drained & dbg_strb_i & ~acc_q & ~dbg_ack_o;

  ////////////////////////////////////////////////////////////
  // Register file access
  ////////////////////////////////////////////////////////////
  assign du_addr_o  = dbg_addr_i[4:0];
  assign du_dato_o  = dbg_dati_i;
  assign du_re_rf_o = acc_q & gpr_hit & ~dbg_we_i;
  assign du_we_rf_o = acc_q & gpr_hit &  dbg_we_i;

  assign dbg_dato_o = rd_hit_q ? du_rf_q_i : '0;  // Misses read zero

  // Sequencer from strobe to access to ack
  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
    begin
      acc_q     <= 1'b0;
      dbg_ack_o <= 1'b0;
      rd_hit_q  <= 1'b0;
    end
    else
    begin
      acc_q     <= start;
      dbg_ack_o <= acc_q;
      rd_hit_q  <= du_re_rf_o;
    end

endmodule

// ==== src/riscv_core.sv ====
// Integer pipeline top level
// Fetch, decode, execute, register file and debug unit

`timescale 1ns/100ps

`include "riscv_defs.svh"

module riscv_core (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  // Instruction fetch
  output logic [`XLEN         -1:0] imem_adr_o,
  output logic                      imem_req_o,
  input  logic                      imem_ack_i,
  input  logic [`XLEN         -1:0] imem_parcel_i,

  // Debug
  input  logic                      dbg_stall_i,
  input  logic                      dbg_strb_i,
  input  logic                      dbg_we_i,
  input  logic [`DBG_ADDR_SIZE-1:0] dbg_addr_i,
  input  logic [`XLEN         -1:0] dbg_dati_i,
  output logic [`XLEN         -1:0] dbg_dato_o,
  output logic                      dbg_ack_o
);

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////
  logic                     if_valid;
  riscv_pkg::instruction_t  if_insn;

  riscv_pkg::rsd_t          rf_src1, rf_src2;
  logic [`XLEN-1:0]         rf_srcv1, rf_srcv2;

  logic [`XLEN-1:0]         ex_r;          // Bypass from execute
  logic                     wb_we;
  riscv_pkg::rsd_t          wb_dst;
  logic [`XLEN-1:0]         wb_r;

  logic                     du_stall;
  logic                     du_re_rf, du_we_rf;
  riscv_pkg::rsd_t          du_addr;
  logic [`XLEN-1:0]         du_dato, du_rf_q;

  riscv_id_ex_if id_ex ();

  ////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////
  riscv_if if_unit (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .imem_adr_o    ( imem_adr_o    ),
    .imem_req_o    ( imem_req_o    ),
    .imem_ack_i    ( imem_ack_i    ),
    .imem_parcel_i ( imem_parcel_i ),
    .du_stall_i    ( du_stall      ),
    .if_valid_o    ( if_valid      ),
    .if_insn_o     ( if_insn       ) );

  riscv_id id_unit (
    .clk_i      ( clk_i    ),
    .arst_n_i   ( arst_n_i ),
    .if_valid_i ( if_valid ),
    .if_insn_i  ( if_insn  ),
    .rf_src1_o  ( rf_src1  ),
    .rf_src2_o  ( rf_src2  ),
    .rf_srcv1_i ( rf_srcv1 ),
    .rf_srcv2_i ( rf_srcv2 ),
    .ex_r_i     ( ex_r     ),
    .wb_we_i    ( wb_we    ),
    .wb_dst_i   ( wb_dst   ),
    .wb_r_i     ( wb_r     ),
    .id_ex      ( id_ex.id ) );

  riscv_ex ex_unit (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .id_ex    ( id_ex.ex ),
    .ex_r_o   ( ex_r     ),
    .wb_we_o  ( wb_we    ),
    .wb_dst_o ( wb_dst   ),
    .wb_r_o   ( wb_r     ) );

  ////////////////////////////////////////////////////////////
  // Register file and debug
  ////////////////////////////////////////////////////////////
  riscv_rf int_rf (
    .clk_i      ( clk_i    ),
    .arst_n_i   ( arst_n_i ),
    .rf_src1_i  ( rf_src1  ),
    .rf_src2_i  ( rf_src2  ),
    .rf_srcv1_o ( rf_srcv1 ),
    .rf_srcv2_o ( rf_srcv2 ),
    .rf_we_i    ( wb_we    ),
    .rf_dst_i   ( wb_dst   ),
    .rf_d_i     ( wb_r     ),
    .du_re_rf_i ( du_re_rf ),
    .du_we_rf_i ( du_we_rf ),
    .du_addr_i  ( du_addr  ),
    .du_d_i     ( du_dato  ),
    .du_rf_q_o  ( du_rf_q  ) );

  riscv_du du_unit (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .dbg_stall_i ( dbg_stall_i ),
    .dbg_strb_i  ( dbg_strb_i  ),
    .dbg_we_i    ( dbg_we_i    ),
    .dbg_addr_i  ( dbg_addr_i  ),
    .dbg_dati_i  ( dbg_dati_i  ),
    .dbg_dato_o  ( dbg_dato_o  ),
    .dbg_ack_o   ( dbg_ack_o   ),
    .du_stall_o  ( du_stall    ),
    .if_valid_i  ( if_valid    ),
    .id_valid_i  ( id_ex.valid ),
    .wb_we_i     ( wb_we       ),
    .imem_req_i  ( imem_req_o  ),
    .du_re_rf_o  ( du_re_rf    ),
    .du_we_rf_o  ( du_we_rf    ),
    .du_addr_o   ( du_addr     ),
    .du_dato_o   ( du_dato     ),
    .du_rf_q_i   ( du_rf_q     ) );

endmodule

// ==== test/riscv_tb_model.svh ====
// Testbench helpers
// LCG, random program generator, reference register model

`ifndef RISCV_TB_MODEL_SVH
`define RISCV_TB_MODEL_SVH

logic [31:0] model_rf [32];   // Expected register contents
logic [31:0] prog [64];       // Served as instruction memory
int          prog_len;

function automatic logic [31:0] lcg_next(inout logic [31:0] s);
  s = s * 32'd1103515245 + 32'd12345;
  return s;
endfunction

// Mode 0 random ALU ops, 1 dependent chain, 2 with unsupported words
function automatic logic [31:0] gen_word(input int mode, input logic [4:0] prev,
                                         inout logic [31:0] s);
  logic [31:0] r;
  logic [31:0] k;
  logic [2:0]  f3;
  logic [4:0]  rd;
  logic [11:0] imm;
  logic [6:0]  f7;
  r   = lcg_next(s);
  k   = lcg_next(s);
  f3  = r[14:12];
  rd  = r[11:7];
  imm = r[31:20];
  f7  = ((f3 == 3'd0 || f3 == 3'd5) && k[20]) ? 7'h20 : 7'h00;
  if (mode == 1)
    return {f7, prev, prev, f3, (rd == 5'd0) ? 5'd1 : rd, `OPC_OP};
  if (mode == 2 && k[25:24] == 2'd0)
    case (k[23:22])
      2'd0   : return {r[31:7], 7'b0000011};                  // Load
      2'd1   : return {r[31:7], 7'b0100011};                  // Store
      2'd2   : return {r[31:7], 7'b1100011};                  // Branch
      default: return {7'h01, r[24:12], rd, `OPC_OP};         // Multiply
    endcase
  case (k[28:27])
    2'd0   : return {f7, r[24:12], rd, `OPC_OP};
    2'd3   : return {r[31:12], rd, `OPC_LUI};
    default:
    begin
      if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = (f3 == 3'd5) ? f7 : 7'h00;
      return {imm, r[19:12], rd, `OPC_OP_IMM};
    end
  endcase
endfunction

// One instruction in program order, per RV32I rules
task automatic model_exec(input logic [31:0] w);
  logic [6:0]  opc;
  logic [6:0]  f7;
  logic [2:0]  f3;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] r;
  logic        ok;
  opc = w[6:0];
  f3  = w[14:12];
  f7  = w[31:25];
  a   = model_rf[w[19:15]];
  b   = model_rf[w[24:20]];
  ok  = 1'b0;
  if (opc == `OPC_OP) ok = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
  if (opc == `OPC_OP_IMM)
  begin
    b  = {{20{w[31]}}, w[31:20]};
    ok = (f3 == 3'd1) ? f7 == 7'h00 : (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20);
  end
  case (f3)
    3'd0   : r = (opc == `OPC_OP && f7[5]) ? a - b : a + b;
    3'd1   : r = a << b[4:0];
    3'd2   : r = {31'd0, $signed(a) < $signed(b)};
    3'd3   : r = {31'd0, a < b};
    3'd4   : r = a ^ b;
    3'd5   :
      if (f7[5]) r = $unsigned($signed(a) >>> b[4:0]);
      else       r = a >> b[4:0];
    3'd6   : r = a | b;
    default: r = a & b;
  endcase
  if (opc == `OPC_LUI)
  begin
    ok = 1'b1;
    r  = {w[31:12], 12'h000};
  end
  if (ok && w[11:7] != 5'd0) model_rf[w[11:7]] = r;
endtask

`endif

// ==== test/riscv_core_tb.sv ====
// Testbench of the integer pipeline
// Clock, reset, instruction memory responder, debug access tasks
// Concurrent checks, watchdog and final report

`timescale 1ns/100ps

`include "riscv_defs.svh"

module riscv_core_tb;

  localparam int N_TESTS  = 5;
  localparam int MAX_PROG = 40;
  localparam int WD_CYCLES = N_TESTS * (20 * MAX_PROG * 4 + 70 * 8);  // Program plus debug time

  logic        clk, arst_n, imem_req, imem_ack, dbg_stall, dbg_strb, dbg_we, dbg_ack;
  logic [31:0] imem_adr, imem_parcel, dbg_dati, dbg_dato;
  logic [15:0] dbg_addr;

  logic [31:0] seed = 32'd55693;
  logic [31:0] ack_seed = 32'd55693 ^ 32'h5a5a_5a5a;   // Separate stream for ack delays
  logic [31:0] ack_adr, last_ack_adr, exp_dato;
  logic        req_seen, waiting, exp_valid;
  int          delay, max_delay, acked_cnt, errors, checks, tests;
  string       test_name = "init";

  `include "riscv_tb_model.svh"

  riscv_core dut (
    .clk_i (clk), .arst_n_i (arst_n),
    .imem_adr_o (imem_adr), .imem_req_o (imem_req), .imem_ack_i (imem_ack),
    .imem_parcel_i (imem_parcel),
    .dbg_stall_i (dbg_stall), .dbg_strb_i (dbg_strb), .dbg_we_i (dbg_we),
    .dbg_addr_i (dbg_addr), .dbg_dati_i (dbg_dati), .dbg_dato_o (dbg_dato),
    .dbg_ack_o (dbg_ack) );

  always #50 clk = ~clk;

  function automatic logic [31:0] fetch_word(input logic [31:0] adr);
    int idx;
    idx = int'((adr - `PC_INIT) >> 2);
    return (idx < prog_len) ? prog[idx] : 32'h0000_0013;  // NOP past the end
  endfunction

  ////////////////////////////////////////////////////////////
  // Instruction memory responder
  ////////////////////////////////////////////////////////////
  always @(negedge clk)
    if (!arst_n)
    begin
      imem_ack  = 1'b0;
      waiting   = 1'b0;
      req_seen  = 1'b0;
      acked_cnt = 0;
    end
    else
    begin
      if (imem_ack)
      begin
        imem_ack     = 1'b0;
        waiting      = 1'b0;
        req_seen     = 1'b1;
        last_ack_adr = ack_adr;
        acked_cnt++;
      end
      if (imem_req)
      begin
        if (!waiting)
        begin
          waiting = 1'b1;
          delay   = int'(lcg_next(ack_seed) >> 16) % (max_delay + 1);
        end
        if (delay == 0)
        begin
          imem_ack    = 1'b1;
          ack_adr     = imem_adr;
          imem_parcel = fetch_word(imem_adr);
        end
        else delay--;
      end
    end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  a_first_adr : assert property (@(posedge clk) disable iff (!arst_n)
    imem_req && !req_seen |-> imem_adr == `PC_INIT)
  else
  begin
    errors++;
    $display("[FAIL] %s first fetch expected %h actual %h", test_name, `PC_INIT, imem_adr);
  end

  a_next_adr : assert property (@(posedge clk) disable iff (!arst_n)
    imem_req && req_seen |-> imem_adr == last_ack_adr + 32'd4)
  else
  begin
    errors++;
    $display("[FAIL] %s fetch address expected %h actual %h",
             test_name, last_ack_adr + 32'd4, imem_adr);
  end

  a_adr_hold : assert property (@(posedge clk) disable iff (!arst_n)
    imem_req && !imem_ack |=> $stable(imem_adr))
  else
  begin
    errors++;
    $display("%s: fetch address changed while waiting", test_name);
  end

  // Under stall no request follows an idle or completing cycle
  a_stall_idle : assert property (@(posedge clk) disable iff (!arst_n)
    dbg_stall && (!imem_req || imem_ack) |=> !imem_req)
  else
  begin
    errors++;
    $display("%s: fetch request raised under stall", test_name);
  end

  a_ack_pulse : assert property (@(posedge clk) disable iff (!arst_n)
    dbg_ack |=> !dbg_ack)
  else
  begin
    errors++;
    $display("%s: debug ack held for more than one cycle", test_name);
  end

  a_dbg_read : assert property (@(posedge clk) disable iff (!arst_n)
    dbg_ack && exp_valid |-> dbg_dato == exp_dato)
  else
  begin
    errors++;
    $display("[FAIL] %s addr %h expected %h actual %h", test_name, dbg_addr, exp_dato, dbg_dato);
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  task automatic dbg_access(input logic we, input logic [15:0] adr,
                            input logic [31:0] d, input logic [31:0] exp);
    @(negedge clk);
    exp_valid = !we;
    exp_dato  = exp;
    dbg_strb  = 1'b1;
    dbg_we    = we;
    dbg_addr  = adr;
    dbg_dati  = d;
    @(negedge clk);
    while (!dbg_ack) @(negedge clk);
    dbg_strb = 1'b0;
    if (!we) checks++;
  endtask

  task automatic run_test(input string name, input int mode, input int len, input int dly);
    int          err0;
    logic [31:0] v;
    logic [4:0]  prev;
    err0      = errors;
    test_name = name;
    max_delay = dly;
    @(negedge clk);
    dbg_stall = 1'b1;
    arst_n    = 1'b0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    // Known start state through debug writes, x0 included
    for (int i = 0; i < 32; i++)
    begin
      v           = lcg_next(seed);
      model_rf[i] = (i == 0) ? 32'd0 : v;
      dbg_access(1'b1, 16'(`DBG_GPR_BASE + i), v, 32'd0);
    end
    prog_len = len;
    prev     = 5'd1;
    for (int i = 0; i < len; i++)
    begin
      prog[i] = gen_word(mode, prev, seed);
      prev    = (prog[i][11:7] == 5'd0) ? prev : prog[i][11:7];
      model_exec(prog[i]);
    end
    @(negedge clk);
    dbg_stall = 1'b0;
    while (acked_cnt < prog_len) @(posedge clk);
    @(negedge clk);
    dbg_stall = 1'b1;
    dbg_access(1'b1, 16'h2005, 32'hdead_beef, 32'd0);  // Unmapped, must not reach x5
    for (int i = 0; i < 32; i++)
      dbg_access(1'b0, 16'(`DBG_GPR_BASE + i), 32'd0, model_rf[i]);
    dbg_access(1'b0, 16'h0405, 32'd0, 32'd0);          // Unmapped, reads zero
    tests++;
    $display("%s: %0d errors", name, errors - err0);
  endtask

  initial
  begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    imem_ack     = 1'b0;
    imem_parcel  = 32'd0;
    dbg_stall    = 1'b1;
    dbg_strb     = 1'b0;
    dbg_we       = 1'b0;
    dbg_addr     = 16'd0;
    dbg_dati     = 32'd0;
    exp_valid    = 1'b0;
    exp_dato     = 32'd0;
    last_ack_adr = 32'd0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    max_delay    = 0;
    delay        = 0;
    prog_len     = 0;
    run_test("random_alu", 0, MAX_PROG, 3);
    run_test("bypass_chain", 1, MAX_PROG, 0);
    run_test("debug_write_then_run", 0, MAX_PROG, 1);
    run_test("stall_and_unmapped", 0, 16, 3);
    run_test("unsupported_mix", 2, MAX_PROG, 2);
    $display("Tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("Watchdog expired before all tests completed");
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+common
+incdir+test
common/riscv_pkg.sv
common/riscv_id_ex_if.sv
core/riscv_if.sv
core/riscv_id.sv
core/riscv_ex.sv
core/riscv_rf.sv
debug/riscv_du.sv
src/riscv_core.sv
test/riscv_core_tb.sv

// ==== Makefile ====
# Verilator simulation of the integer pipeline

VERILATOR ?= verilator
TOP       ?= riscv_core_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
